// ==== Bender.yml ====
package:
  name: exc_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cpu_pkg.sv
      - src/cpu_ifs.sv
      - src/mem_stage_reg.sv
      - src/exc_handler.sv
      - src/cp0_regs.sv
      - src/exc_unit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_exc_unit.sv

// ==== bench/tb_exc_unit.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module tb_exc_unit;

	logic        clk;
	logic        arst_n;
	logic        stall;
	logic        ex_valid;
	logic [31:0] ex_pc;
	logic [31:0] ex_badvaddr;
	logic        ex_in_delay_slot;
	logic [1:0]  ex_addr_err;
	logic        ex_reserved_instr;
	logic        ex_intovf;
	logic        ex_break;
	logic        ex_syscall;
	logic        ex_eret;
	logic        ex_mtc0_wen;
	logic [4:0]  ex_mtc0_addr;
	logic [31:0] ex_mtc0_wdata;
	logic [4:0]  hw_int;
	logic [4:0]  cp0_raddr;
	logic [31:0] cp0_rdata;
	logic        exc_flush;
	logic [31:0] exc_target;
	logic        timer_int;

	integer      seed = 24162;
	int          errors = 0;
	int          seq_errors = 0;
	logic [31:0] got_target;

	// Reference copy of Status, EPC, Cause.BD and BadVAddr
	logic [31:0] m_status = '0;
	logic [31:0] m_epc = '0;
	logic        m_bd = 1'b0;
	logic [31:0] m_badvaddr = '0;

	exc_unit_top i_exc_unit_top (.*);

	always #4 clk = ~clk;

	// Flushed entry becomes a bubble, so no exception commits twice
	flush_once: assert property (@(posedge clk) disable iff (!arst_n) exc_flush |=> !exc_flush)
		else begin
			$display("Fail at %0t: exc_flush expected 0 actual 1", $time);
			seq_errors++;
		end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic drive(input logic v, input logic [31:0] pc, input logic [6:0] fl,
		input logic ds, input logic [31:0] bva, input logic wen, input logic [4:0] waddr,
		input logic [31:0] wdata);
		ex_valid         = v;
		ex_pc            = pc;
		ex_badvaddr      = bva;
		ex_in_delay_slot = ds;
		{ex_addr_err, ex_reserved_instr, ex_intovf, ex_break, ex_syscall, ex_eret} = fl;
		ex_mtc0_wen      = wen;
		ex_mtc0_addr     = waddr;
		ex_mtc0_wdata    = wdata;
	endtask

	task automatic read_cp0(input logic [4:0] addr, output logic [31:0] data);
		@(negedge clk);
		cp0_raddr = addr;
		#1;
		data = cp0_rdata;
	endtask

	// One instruction through the stage; returns after edge k+1
	task automatic issue(input logic [31:0] pc, input logic [6:0] fl, input logic ds,
		input logic [31:0] bva, input logic wen, input logic [4:0] waddr,
		input logic [31:0] wdata, input logic exp_flush);
		int cycles;
		@(negedge clk);
		drive(1'b1, pc, fl, ds, bva, wen, waddr, wdata);
		@(negedge clk);
		drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0);
		if (exp_flush) begin
			cycles = 0;
			while (!exc_flush && cycles < 8) begin
				@(negedge clk);
				cycles++;
			end
			if (!exc_flush) begin
				$display("Timed out waiting for exc_flush after pc %h", pc);
				errors++;
			end
			got_target = exc_target;
		end else begin
			check("exc_flush", 32'd0, {31'd0, exc_flush});
		end
		@(negedge clk);
	endtask

	task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
		issue(32'd0, 7'd0, 1'b0, 32'd0, 1'b1, addr, data, 1'b0);
		if (addr == cpu_pkg::status_r)
			m_status = (m_status & ~`STATUS_WMASK) | (data & `STATUS_WMASK);
		else if (addr == cpu_pkg::epc_r)
			m_epc = data;
	endtask

	task automatic check_state();
		logic [31:0] rd;
		read_cp0(cpu_pkg::status_r, rd);
		check("status", m_status, rd);
		read_cp0(cpu_pkg::epc_r, rd);
		check("epc", m_epc, rd);
		read_cp0(cpu_pkg::badvaddr_r, rd);
		check("badvaddr", m_badvaddr, rd);
		read_cp0(cpu_pkg::cause_r, rd);
		check("cause.bd", {31'd0, m_bd}, {31'd0, rd[31]});
	endtask

	//////////////////////////////
	// Priority without interrupts
	//////////////////////////////
	function automatic logic [4:0] expected_code(input logic [6:0] fl);
		if (fl[6:5] == 2'b01) return cpu_pkg::adel_c;
		if (fl[4]) return cpu_pkg::ri_c;
		if (fl[3]) return cpu_pkg::ov_c;
		if (fl[2]) return cpu_pkg::bp_c;
		if (fl[1]) return cpu_pkg::sys_c;
		if (fl[6:5] == 2'b10) return cpu_pkg::adel_c;
		if (fl[6:5] == 2'b11) return cpu_pkg::ades_c;
		return cpu_pkg::int_c;
	endfunction

	task automatic take_exception(input logic [31:0] pc, input logic [6:0] fl, input logic ds,
		input logic [31:0] bva, input logic [4:0] code);
		logic [31:0] rd;
		issue(pc, fl, ds, bva, 1'b0, 5'd0, 32'd0, 1'b1);
		check("exc_target", `EXC_VECTOR, got_target);
		// Nested exception keeps the first EPC and BD
		if (!m_status[1]) begin
			m_epc = ds ? pc - 32'd4 : pc;
			m_bd  = ds;
		end
		m_status[1] = 1'b1;
		if (fl[6:5] != 2'b00)
			m_badvaddr = bva;
		read_cp0(cpu_pkg::cause_r, rd);
		check("cause.exccode", {27'd0, code}, {27'd0, rd[6:2]});
		check_state();
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] pc;
		logic [31:0] bva;
		logic [6:0]  fl;
		int          i;
		int          nflush;
		clk       = 1'b0;
		arst_n    = 1'b0;
		stall     = 1'b0;
		hw_int    = '0;
		cp0_raddr = '0;
		drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0);
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		check_state();
		read_cp0(cpu_pkg::compare_r, rd);
		check("compare", `COMPARE_RESET, rd);
		check("timer_int", 32'd0, {31'd0, timer_int});

		// Random flag sets with EXL and IE clear
		for (i = 0; i < 24; i++) begin
			rd  = $random(seed);
			pc  = $random(seed) & 32'hFFFF_FFFC;
			bva = $random(seed);
			fl  = rd[6:0] & rd[14:8] & rd[22:16] & 7'b111_1110;
			if (fl != 7'd0) begin
				take_exception(pc, fl, rd[24], bva, expected_code(fl));
				write_cp0(cpu_pkg::status_r, 32'd0);
			end else begin
				issue(pc, fl, rd[24], bva, 1'b0, 5'd0, 32'd0, 1'b0);
				check_state();
			end
		end

		// Fetch, load and store address errors in turn
		for (i = 1; i < 4; i++) begin
			fl  = {i[1:0], 5'd0};
			bva = $random(seed);
			take_exception(32'h0040_0010 + 4 * i, fl, 1'b0, bva, expected_code(fl));
			write_cp0(cpu_pkg::status_r, 32'd0);
		end

		// Second exception while EXL is set
		take_exception(32'h0040_0100, 7'b000_0010, 1'b1, 32'd0, cpu_pkg::sys_c);
		take_exception(32'h0040_0200, 7'b000_0100, 1'b0, 32'd0, cpu_pkg::bp_c);

		//////////////////////////////
		// Interrupts
		//////////////////////////////
		write_cp0(cpu_pkg::status_r, 32'h0000_0401);
		@(negedge clk);
		hw_int = 5'b00001;
		take_exception(32'h0040_0300, 7'd0, 1'b0, 32'd0, cpu_pkg::int_c);
		issue(32'h0040_0304, 7'd0, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b0);
		write_cp0(cpu_pkg::status_r, 32'h0000_0400);
		issue(32'h0040_0308, 7'd0, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b0);
		write_cp0(cpu_pkg::status_r, 32'h0000_0801);
		issue(32'h0040_030C, 7'd0, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b0);
		hw_int = 5'b00000;
		write_cp0(cpu_pkg::status_r, 32'd0);
		check_state();

		// eret returns to EPC and clears EXL
		write_cp0(cpu_pkg::epc_r, 32'h0040_1000);
		write_cp0(cpu_pkg::status_r, 32'h0000_0002);
		issue(32'h0040_2000, 7'b000_0001, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0, 1'b1);
		check("exc_target", m_epc, got_target);
		m_status[1] = 1'b0;
		check_state();

		// Younger instruction captured on the flush edge is dropped
		@(negedge clk);
		drive(1'b1, 32'h0040_3000, 7'b000_0010, 1'b0, '0, 1'b0, '0, '0);
		@(negedge clk);
		check("exc_flush", 32'd1, {31'd0, exc_flush});
		drive(1'b1, 32'h0040_3004, 7'b000_0010, 1'b0, '0, 1'b0, '0, '0);
		@(negedge clk);
		drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0);
		check("exc_flush", 32'd0, {31'd0, exc_flush});
		m_epc       = 32'h0040_3000;
		m_bd        = 1'b0;
		m_status[1] = 1'b1;
		check_state();
		write_cp0(cpu_pkg::status_r, 32'd0);

		// Held exception under stall
		@(negedge clk);
		drive(1'b1, 32'h0040_4000, 7'b000_1000, 1'b1, '0, 1'b0, '0, '0);
		nflush = 0;
		repeat (4) begin
			@(negedge clk);
			drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0);
			stall = 1'b1;
			if (exc_flush)
				nflush++;
		end
		stall = 1'b0;
		check("flush count", 32'd1, nflush);
		m_epc       = 32'h0040_3FFC;
		m_bd        = 1'b1;
		m_status[1] = 1'b1;
		check_state();
		write_cp0(cpu_pkg::status_r, 32'd0);

		//////////////////////////////
		// Timer
		//////////////////////////////
		read_cp0(cpu_pkg::count_r, rd);
		pc = rd + 32'd12;
		write_cp0(cpu_pkg::compare_r, pc);
		read_cp0(cpu_pkg::compare_r, rd);
		check("compare", pc, rd);
		i = 0;
		while (!timer_int && i < 40) begin
			@(negedge clk);
			i++;
		end
		if (!timer_int) begin
			$display("Timed out waiting for timer_int");
			errors++;
		end
		read_cp0(cpu_pkg::cause_r, rd);
		check("cause.ip7", 32'd1, {31'd0, rd[15]});
		write_cp0(cpu_pkg::compare_r, `COMPARE_RESET);
		check("timer_int", 32'd0, {31'd0, timer_int});
		read_cp0(cpu_pkg::cause_r, rd);
		check("cause.ip7", 32'd0, {31'd0, rd[15]});

		$display("Errors: %0d check, %0d sequence", errors, seq_errors);
		if (errors + seq_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

//////////////////////////////
// Datapath
//////////////////////////////
`define XLEN 32

// Common exception entry, EXL=0 and BEV=1
`define EXC_VECTOR 32'hBFC0_0380

//////////////////////////////
// CP0 reset and write masks
//////////////////////////////
`define COMPARE_RESET 32'hFFFF_FFFF

// IM[15:8], EXL and IE
`define STATUS_WMASK 32'h0000_FF03

// Software interrupt bits IP[9:8]
`define CAUSE_WMASK 32'h0000_0300

`endif

// ==== src/cp0_regs.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cp0_regs (
	input  logic               clk,
	input  logic               arst_n,
	exc_req_if.cp0             req,
	cp0_update_if.cp0          upd,
	input  logic [4:0]         hw_int,
	input  cpu_pkg::cp0_addr_t raddr,
	output logic [`XLEN-1:0]   rdata,
	output logic [`XLEN-1:0]   epc,
	output logic [`XLEN-1:0]   status,
	output logic [`XLEN-1:0]   cause,
	output logic               timer_int
);

	logic [`XLEN-1:0] badvaddr_q;
	logic [`XLEN-1:0] count_q;
	logic [`XLEN-1:0] compare_q;
	logic [`XLEN-1:0] status_q;
	logic [`XLEN-1:0] epc_q;
	logic             cause_bd;
	logic [7:0]       cause_ip;
	cpu_pkg::exccode_t cause_exccode;

	logic             side_apply;
	logic             sw_wen;
	logic [`XLEN-1:0] cause_sw;

	// Exception commit blocks the eret Status write but not BadVAddr
	assign side_apply = upd.side_wen
		&& (!upd.exc_valid || upd.side_waddr == cpu_pkg::badvaddr_r);
	assign sw_wen = req.valid && req.mtc0_wen && !upd.exc_valid && !upd.side_wen;

	assign cause_sw = req.mtc0_wdata & `CAUSE_WMASK;

	//////////////////////////////
	// Register updates
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			badvaddr_q    <= '0;
			count_q       <= '0;
			compare_q     <= `COMPARE_RESET;
			status_q      <= '0;
			epc_q         <= '0;
			cause_bd      <= 1'b0;
			cause_ip      <= '0;
			cause_exccode <= cpu_pkg::int_c;
		end else begin
			count_q       <= count_q + 1'b1;
			cause_ip[6:2] <= hw_int;
			// Timer match is sticky until Compare is rewritten
			if (count_q == compare_q)
				cause_ip[7] <= 1'b1;

			if (upd.exc_valid) begin
				epc_q         <= upd.epc_wdata;
				cause_bd      <= upd.bd_wdata;
				cause_exccode <= upd.exccode_wdata;
				status_q[cpu_pkg::status_exl_bit] <= 1'b1;
			end

			if (side_apply) begin
				case (upd.side_waddr)
					cpu_pkg::badvaddr_r: badvaddr_q <= upd.side_wdata;
					cpu_pkg::status_r: status_q <= (status_q & ~`STATUS_WMASK)
						| (upd.side_wdata & `STATUS_WMASK);
					default: ;
				endcase
			end

			// mtc0 cannot write BadVAddr
			if (sw_wen) begin
				case (req.mtc0_addr)
					cpu_pkg::count_r: count_q <= req.mtc0_wdata;
					cpu_pkg::compare_r: begin
						compare_q   <= req.mtc0_wdata;
						cause_ip[7] <= 1'b0;
					end
					cpu_pkg::status_r: status_q <= (status_q & ~`STATUS_WMASK)
						| (req.mtc0_wdata & `STATUS_WMASK);
					cpu_pkg::cause_r: cause_ip[1:0] <= cause_sw[9:8];
					cpu_pkg::epc_r: epc_q <= req.mtc0_wdata;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Outputs and read port
	//////////////////////////////
	assign cause = {cause_bd, 15'b0, cause_ip, 1'b0, cause_exccode, 2'b00};
	assign status    = status_q;
	assign epc       = epc_q;
	assign timer_int = cause_ip[7];

	always_comb begin
		case (raddr)
			cpu_pkg::badvaddr_r: rdata = badvaddr_q;
			cpu_pkg::count_r:    rdata = count_q;
			cpu_pkg::compare_r:  rdata = compare_q;
			cpu_pkg::status_r:   rdata = status_q;
			cpu_pkg::cause_r:    rdata = cause;
			cpu_pkg::epc_r:      rdata = epc_q;
			default:             rdata = '0;
		endcase
	end

endmodule

// ==== src/cpu_ifs.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

// Memory-stage instruction as seen by the handler and CP0
interface exc_req_if;
	logic                   valid;
	logic [`XLEN-1:0]       pc;
	logic [`XLEN-1:0]       badvaddr;
	logic                   in_delay_slot;
	cpu_pkg::exc_flags_t    flags;
	logic                   mtc0_wen;
	cpu_pkg::cp0_addr_t     mtc0_addr;
	logic [`XLEN-1:0]       mtc0_wdata;

	modport stage (output valid, pc, badvaddr, in_delay_slot, flags,
		mtc0_wen, mtc0_addr, mtc0_wdata);
	modport handler (input valid, pc, badvaddr, in_delay_slot, flags);
	modport cp0 (input valid, mtc0_wen, mtc0_addr, mtc0_wdata);
endinterface

// Exception commit and side write toward CP0
interface cp0_update_if;
	logic                   exc_valid;
	logic [`XLEN-1:0]       epc_wdata;
	logic                   bd_wdata;
	cpu_pkg::exccode_t      exccode_wdata;
	logic                   side_wen;
	cpu_pkg::cp0_addr_t     side_waddr;
	logic [`XLEN-1:0]       side_wdata;

	modport handler (output exc_valid, epc_wdata, bd_wdata, exccode_wdata,
		side_wen, side_waddr, side_wdata);
	modport cp0 (input exc_valid, epc_wdata, bd_wdata, exccode_wdata,
		side_wen, side_waddr, side_wdata);
endinterface

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	//////////////////////////////
	// Cause.ExcCode values
	//////////////////////////////
	typedef enum logic [4:0] {
		int_c  = 5'd0,
		adel_c = 5'd4,
		ades_c = 5'd5,
		sys_c  = 5'd8,
		bp_c   = 5'd9,
		ri_c   = 5'd10,
		ov_c   = 5'd12
	} exccode_t;

	// CP0 register numbers, select 0 only
	typedef enum logic [4:0] {
		badvaddr_r = 5'd8,
		count_r    = 5'd9,
		compare_r  = 5'd11,
		status_r   = 5'd12,
		cause_r    = 5'd13,
		epc_r      = 5'd14
	} cp0_addr_t;

	// Exception flags raised by earlier stages
	typedef struct packed {
		logic [1:0] addr_err;
		logic       reserved_instr;
		logic       intovf;
		logic       brk;
		logic       syscall;
		logic       eret;
	} exc_flags_t;

	// Bit positions inside Status and Cause
	localparam int status_ie_bit  = 0;
	localparam int status_exl_bit = 1;
	localparam int cause_bd_bit   = 31;

endpackage

// ==== src/exc_handler.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module exc_handler (
	exc_req_if.handler        req,
	input  logic [`XLEN-1:0]  epc,
	input  logic [`XLEN-1:0]  status,
	input  logic [`XLEN-1:0]  cause,
	cp0_update_if.handler     upd,
	output logic              exc_flush,
	output logic [`XLEN-1:0]  exc_target
);

	logic              int_pending;
	logic              exc_taken;
	logic              exl;
	cpu_pkg::exccode_t exccode;

	assign exl = status[cpu_pkg::status_exl_bit];

	// Pending and unmasked, globally enabled, not already in a handler
	assign int_pending = (|(cause[15:8] & status[15:8]))
		&& status[cpu_pkg::status_ie_bit] && !exl;

	//////////////////////////////
	// Priority encoder
	//////////////////////////////
	always_comb begin
		exc_taken = 1'b1;
		exccode   = cpu_pkg::int_c;
		if (!req.valid) begin
			exc_taken = 1'b0;
		end else if (int_pending) begin
			exccode = cpu_pkg::int_c;
		end else if (req.flags.addr_err == 2'b01) begin
			exccode = cpu_pkg::adel_c;
		end else if (req.flags.reserved_instr) begin
			exccode = cpu_pkg::ri_c;
		end else if (req.flags.intovf) begin
			exccode = cpu_pkg::ov_c;
		end else if (req.flags.brk) begin
			exccode = cpu_pkg::bp_c;
		end else if (req.flags.syscall) begin
			exccode = cpu_pkg::sys_c;
		end else if (req.flags.addr_err == 2'b10) begin
			exccode = cpu_pkg::adel_c;
		end else if (req.flags.addr_err == 2'b11) begin
			exccode = cpu_pkg::ades_c;
		end else begin
			exc_taken = 1'b0;
		end
	end

	// Nested exception keeps the first return point
	always_comb begin
		if (exl) begin
			upd.epc_wdata = epc;
			upd.bd_wdata  = cause[cpu_pkg::cause_bd_bit];
		end else if (req.in_delay_slot) begin
			upd.epc_wdata = req.pc - `XLEN'd4;
			upd.bd_wdata  = 1'b1;
		end else begin
			upd.epc_wdata = req.pc;
			upd.bd_wdata  = 1'b0;
		end
	end

	//////////////////////////////
	// Side writes
	//////////////////////////////
	always_comb begin
		upd.side_wen   = 1'b0;
		upd.side_waddr = cpu_pkg::badvaddr_r;
		upd.side_wdata = '0;
		if (req.valid && req.flags.addr_err != 2'b00) begin
			upd.side_wen   = 1'b1;
			upd.side_wdata = req.badvaddr;
		end else if (req.valid && req.flags.eret) begin
			upd.side_wen   = 1'b1;
			upd.side_waddr = cpu_pkg::status_r;
			upd.side_wdata = status;
			upd.side_wdata[cpu_pkg::status_exl_bit] = 1'b0;
		end
	end

	assign upd.exc_valid     = exc_taken;
	assign upd.exccode_wdata = exccode;

	// eret returns to EPC unless something else fires first
	assign exc_flush  = exc_taken || (req.valid && req.flags.eret);
	assign exc_target = exc_taken ? `EXC_VECTOR : epc;

endmodule

// ==== src/exc_unit_top.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module exc_unit_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              stall,
	input  logic              ex_valid,
	input  logic [`XLEN-1:0]  ex_pc,
	input  logic [`XLEN-1:0]  ex_badvaddr,
	input  logic              ex_in_delay_slot,
	input  logic [1:0]        ex_addr_err,
	input  logic              ex_reserved_instr,
	input  logic              ex_intovf,
	input  logic              ex_break,
	input  logic              ex_syscall,
	input  logic              ex_eret,
	input  logic              ex_mtc0_wen,
	input  logic [4:0]        ex_mtc0_addr,
	input  logic [`XLEN-1:0]  ex_mtc0_wdata,
	input  logic [4:0]        hw_int,
	input  logic [4:0]        cp0_raddr,
	output logic [`XLEN-1:0]  cp0_rdata,
	output logic              exc_flush,
	output logic [`XLEN-1:0]  exc_target,
	output logic              timer_int
);

	cpu_pkg::exc_flags_t ex_flags;
	logic [`XLEN-1:0]    epc;
	logic [`XLEN-1:0]    status;
	logic [`XLEN-1:0]    cause;

	exc_req_if    i_exc_req ();
	cp0_update_if i_cp0_upd ();

	assign ex_flags = '{addr_err: ex_addr_err, reserved_instr: ex_reserved_instr,
		intovf: ex_intovf, brk: ex_break, syscall: ex_syscall, eret: ex_eret};

	// Flush feeds back so the faulting entry becomes a bubble
	mem_stage_reg i_mem_stage_reg (
		.clk(clk), .arst_n(arst_n), .stall(stall), .flush(exc_flush),
		.ex_valid(ex_valid), .ex_pc(ex_pc), .ex_badvaddr(ex_badvaddr),
		.ex_in_delay_slot(ex_in_delay_slot), .ex_flags(ex_flags),
		.ex_mtc0_wen(ex_mtc0_wen), .ex_mtc0_addr(cpu_pkg::cp0_addr_t'(ex_mtc0_addr)),
		.ex_mtc0_wdata(ex_mtc0_wdata), .req(i_exc_req.stage)
	);

	exc_handler i_exc_handler (
		.req(i_exc_req.handler), .epc(epc), .status(status), .cause(cause),
		.upd(i_cp0_upd.handler), .exc_flush(exc_flush), .exc_target(exc_target)
	);

	cp0_regs i_cp0_regs (
		.clk(clk), .arst_n(arst_n), .req(i_exc_req.cp0), .upd(i_cp0_upd.cp0),
		.hw_int(hw_int), .raddr(cpu_pkg::cp0_addr_t'(cp0_raddr)), .rdata(cp0_rdata),
		.epc(epc), .status(status), .cause(cause), .timer_int(timer_int)
	);

endmodule

// ==== src/mem_stage_reg.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module mem_stage_reg (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                stall,
	input  logic                flush,
	input  logic                ex_valid,
	input  logic [`XLEN-1:0]    ex_pc,
	input  logic [`XLEN-1:0]    ex_badvaddr,
	input  logic                ex_in_delay_slot,
	input  cpu_pkg::exc_flags_t ex_flags,
	input  logic                ex_mtc0_wen,
	input  cpu_pkg::cp0_addr_t  ex_mtc0_addr,
	input  logic [`XLEN-1:0]    ex_mtc0_wdata,
	exc_req_if.stage            req
);

	//////////////////////////////
	// Control part
	//////////////////////////////
	// Flush beats stall so a held exception cannot commit twice
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req.valid    <= 1'b0;
			req.flags    <= '0;
			req.mtc0_wen <= 1'b0;
		end else if (flush) begin
			req.valid    <= 1'b0;
			req.flags    <= '0;
			req.mtc0_wen <= 1'b0;
		end else if (!stall) begin
			req.valid    <= ex_valid;
			req.flags    <= ex_flags;
			req.mtc0_wen <= ex_mtc0_wen;
		end
	end

	//////////////////////////////
	// Payload part
	//////////////////////////////
	// Contents of a bubble are don't care
	always_ff @(posedge clk) begin
		if (!stall) begin
			req.pc            <= ex_pc;
			req.badvaddr      <= ex_badvaddr;
			req.in_delay_slot <= ex_in_delay_slot;
			req.mtc0_addr     <= ex_mtc0_addr;
			req.mtc0_wdata    <= ex_mtc0_wdata;
		end
	end

endmodule

// ==== verilog.f ====
+incdir+include
src/cpu_pkg.sv
src/cpu_ifs.sv
src/mem_stage_reg.sv
src/exc_handler.sv
src/cp0_regs.sv
src/exc_unit_top.sv
bench/tb_exc_unit.sv
